/* design/cpu_cfg_pkg.sv */
package cpu_cfg_pkg;

    localparam int addr_w = 20;             // byte address bits.
    localparam int data_w = 16;
    localparam int byte_w = data_w / 2;
    localparam int prefetch_depth = 4;      // words.
    localparam int mem_words = 1024;        // upper word address bits alias.
    localparam int wait_states = 1;         // ack is registered so one or more.

    localparam int fifo_ptr_w = $clog2(prefetch_depth);
    localparam int fifo_cnt_w = $clog2(prefetch_depth + 1);
    localparam int mem_idx_w = $clog2(mem_words);
    localparam int wait_cnt_w = (wait_states > 1) ? $clog2(wait_states) : 1;

    // counter value in the last cycle before ack.
    localparam logic [wait_cnt_w-1:0] wait_last = wait_cnt_w'(wait_states - 1);

endpackage

/* design/mem_bus_pkg.sv */
package mem_bus_pkg;

    // word address, bit 0 of the byte address dropped.
    typedef logic [cpu_cfg_pkg::addr_w-1:1] word_addr_t;

    typedef struct packed {
        word_addr_t                      addr;
        logic [cpu_cfg_pkg::data_w-1:0]  wdata;
        logic                            wr_en;
        logic [1:0]                      bytesel;   // bit 0 selects the low byte.
    } mem_req_t;

    localparam logic [1:0] byte_sel_both = 2'b11;
    localparam logic [1:0] byte_sel_low = 2'b01;
    localparam logic [1:0] byte_sel_high = 2'b10;

endpackage

/* design/prefetch_queue.sv */
`timescale 1ns/100ps

module prefetch_queue
    import cpu_cfg_pkg::*, mem_bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              fetch_start,
    input  word_addr_t        fetch_addr,
    input  logic              instr_pop,
    output logic              instr_valid,
    output logic [data_w-1:0] instr_word,
    output logic              bus_access,
    output mem_req_t          bus_req,
    input  logic              bus_ack,
    input  logic [data_w-1:0] bus_rdata
);

    logic [data_w-1:0] fifo [prefetch_depth];
    logic [fifo_ptr_w-1:0] rd_ptr;
    logic [fifo_ptr_w-1:0] wr_ptr;
    logic [fifo_cnt_w-1:0] count;
    logic [fifo_cnt_w-1:0] count_next;
    logic running;
    logic busy;                 // a fetch is on the bus.
    logic discard;              // drop the word of the fetch in flight.
    word_addr_t next_addr;
    word_addr_t req_addr;
    word_addr_t issue_addr;
    logic push;
    logic pop;
    logic issue;

    function automatic logic [fifo_ptr_w-1:0] ptr_inc(input logic [fifo_ptr_w-1:0] ptr);
        if (ptr == fifo_ptr_w'(prefetch_depth - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    always_comb begin
        push = bus_ack & ~discard & ~fetch_start;   // a flush in the ack cycle drops it too.
        pop = instr_pop & instr_valid & ~fetch_start;
        if (fetch_start)
            count_next = '0;
        else
            count_next = count + fifo_cnt_w'(push) - fifo_cnt_w'(pop);
        // the next fetch must fit beside what the FIFO holds after this edge.
        issue = (running | fetch_start) & (~busy | bus_ack) & (count_next < prefetch_depth);
        issue_addr = fetch_start ? fetch_addr : next_addr;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            busy <= 1'b0;
            discard <= 1'b0;
            count <= '0;
            rd_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            count <= count_next;
            if (fetch_start)
                running <= 1'b1;
            if (fetch_start) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
            end else begin
                if (push)
                    wr_ptr <= ptr_inc(wr_ptr);
                if (pop)
                    rd_ptr <= ptr_inc(rd_ptr);
            end
            if (bus_ack)
                discard <= 1'b0;
            else if (fetch_start && busy)
                discard <= 1'b1;    // request still held until its ack.
            if (issue)
                busy <= 1'b1;
            else if (bus_ack)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            fifo[wr_ptr] <= bus_rdata;
        if (issue) begin
            req_addr <= issue_addr;
            next_addr <= issue_addr + 1'b1;
        end else if (fetch_start) begin
            next_addr <= fetch_addr;
        end
    end

    assign instr_valid = (count != '0);
    assign instr_word = fifo[rd_ptr];

    assign bus_access = busy;
    assign bus_req.addr = req_addr;
    assign bus_req.wdata = '0;
    assign bus_req.wr_en = 1'b0;
    assign bus_req.bytesel = byte_sel_both;

    req_stable_a: assert property (@(posedge clk) disable iff (reset)
        bus_access && !bus_ack |=> bus_access && $stable(bus_req));

    count_bound_a: assert property (@(posedge clk) disable iff (reset)
        count <= prefetch_depth);

endmodule

/* design/data_port.sv */
`timescale 1ns/100ps

module data_port
    import cpu_cfg_pkg::*, mem_bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              data_start,
    input  logic [addr_w-1:0] data_addr,
    input  logic              data_word,
    input  logic              data_wr,
    input  logic [data_w-1:0] data_wdata,
    output logic              data_busy,
    output logic              data_done,
    output logic [data_w-1:0] data_rdata,
    output logic              bus_access,
    output mem_req_t          bus_req,
    input  logic              bus_ack,
    input  logic [data_w-1:0] bus_rdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_first,
        st_second
    } state_t;

    state_t state;
    logic done;
    mem_req_t req_q;
    mem_req_t start_req;
    mem_req_t second_req;
    logic split_q;              // unaligned word, two bus cycles.
    logic odd_q;
    logic word_q;
    logic [byte_w-1:0] hi_q;
    logic [data_w-1:0] rdata_q;
    logic [byte_w-1:0] lo_byte;
    logic [byte_w-1:0] hi_byte;

    assign lo_byte = data_wdata[byte_w-1:0];
    assign hi_byte = data_wdata[data_w-1:byte_w];

    always_comb begin
        start_req.addr = data_addr[addr_w-1:1];
        start_req.wr_en = data_wr;
        if (data_word && !data_addr[0]) begin
            start_req.bytesel = byte_sel_both;
            start_req.wdata = data_wdata;
        end else if (data_addr[0]) begin
            // odd byte, or first half of an unaligned word.
            start_req.bytesel = byte_sel_high;
            start_req.wdata = {lo_byte, lo_byte};
        end else begin
            start_req.bytesel = byte_sel_low;
            start_req.wdata = {lo_byte, lo_byte};
        end
    end

    always_comb begin
        second_req.addr = req_q.addr + 1'b1;
        second_req.wr_en = req_q.wr_en;
        second_req.bytesel = byte_sel_low;
        second_req.wdata = {hi_q, hi_q};
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (data_start)
                        state <= st_first;
                end
                st_first: begin
                    if (bus_ack && split_q) begin
                        state <= st_second;
                    end else if (bus_ack) begin
                        state <= st_idle;
                        done <= 1'b1;
                    end
                end
                st_second: begin
                    if (bus_ack) begin
                        state <= st_idle;
                        done <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (data_start && state == st_idle) begin
            req_q <= start_req;
            split_q <= data_word & data_addr[0];
            odd_q <= data_addr[0];
            word_q <= data_word;
            hi_q <= hi_byte;
        end else if (state == st_first && bus_ack && split_q) begin
            req_q <= second_req;
        end
        if (bus_ack) begin
            if (state == st_second)
                rdata_q[data_w-1:byte_w] <= bus_rdata[byte_w-1:0];
            else if (split_q)
                rdata_q[byte_w-1:0] <= bus_rdata[data_w-1:byte_w];
            else if (word_q)
                rdata_q <= bus_rdata;
            else if (odd_q)
                rdata_q <= {{byte_w{1'b0}}, bus_rdata[data_w-1:byte_w]};
            else
                rdata_q <= {{byte_w{1'b0}}, bus_rdata[byte_w-1:0]};
        end
    end

    assign data_busy = (state != st_idle);
    assign data_done = done;
    assign data_rdata = rdata_q;
    assign bus_access = (state != st_idle);
    assign bus_req = req_q;

    req_stable_a: assert property (@(posedge clk) disable iff (reset)
        bus_access && !bus_ack |=> bus_access && $stable(bus_req));

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter
    import cpu_cfg_pkg::*, mem_bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_access,
    input  mem_req_t          instr_req,
    output logic              instr_ack,
    input  logic              data_access,
    input  mem_req_t          data_req,
    output logic              data_ack,
    input  logic [data_w-1:0] bus_rdata_in,
    output logic [data_w-1:0] rdata,
    output logic              q_access,
    output mem_req_t          q_req,
    input  logic              q_ack
);

    logic instr_grant;
    logic data_grant;
    logic instr_will_grant;
    logic data_will_grant;
    logic q_data;

    // data wins unless instruction already holds the bus.
    assign data_will_grant = data_access & ~instr_grant & ~data_grant;
    assign instr_will_grant = instr_access & ~data_access & ~data_grant & ~instr_grant;

    assign q_data = data_will_grant | data_grant;

    assign q_access = q_data ? data_access : instr_access;
    assign q_req = q_data ? data_req : instr_req;

    assign instr_ack = instr_grant & q_ack;
    assign data_ack = data_grant & q_ack;
    assign rdata = bus_rdata_in;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_grant <= 1'b0;
            data_grant <= 1'b0;
        end else begin
            if (data_ack)
                data_grant <= 1'b0;
            if (instr_ack)
                instr_grant <= 1'b0;
            if (data_will_grant)
                data_grant <= 1'b1;
            else if (instr_will_grant)
                instr_grant <= 1'b1;
        end
    end

    one_grant_a: assert property (@(posedge clk) disable iff (reset)
        !(instr_grant && data_grant));

    ack_with_access_a: assert property (@(posedge clk) disable iff (reset)
        q_ack |-> q_access);

endmodule

/* design/sram_ctrl.sv */
`timescale 1ns/100ps

module sram_ctrl
    import cpu_cfg_pkg::*, mem_bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              access,
    input  mem_req_t          req,
    output logic              ack,
    output logic [data_w-1:0] rdata
);

    logic [data_w-1:0] mem [mem_words];
    logic [wait_cnt_w-1:0] wait_cnt;
    logic [mem_idx_w-1:0] idx;
    logic hit;                  // last wait cycle, access happens here.

    assign idx = req.addr[mem_idx_w:1];
    assign hit = access & ~ack & (wait_cnt == wait_last);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack <= 1'b0;
            wait_cnt <= '0;
        end else begin
            ack <= hit;
            if (!access || ack || hit)
                wait_cnt <= '0;
            else
                wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            if (req.wr_en) begin
                if (req.bytesel[0])
                    mem[idx][byte_w-1:0] <= req.wdata[byte_w-1:0];
                if (req.bytesel[1])
                    mem[idx][data_w-1:byte_w] <= req.wdata[data_w-1:byte_w];
            end else begin
                rdata <= mem[idx];
            end
        end
    end

    // the routed master holds its request until the ack.
    req_held_a: assert property (@(posedge clk) disable iff (reset)
        access && !ack |=> access && $stable(req));

endmodule

/* design/mem_subsystem_top.sv */
`timescale 1ns/100ps

module mem_subsystem_top
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        fetch_start,
    input  word_addr_t  fetch_addr,
    input  logic        instr_pop,
    output logic        instr_valid,
    output logic [15:0] instr_word,
    input  logic        data_start,
    input  logic [19:0] data_addr,
    input  logic        data_word,
    input  logic        data_wr,
    input  logic [15:0] data_wdata,
    output logic        data_busy,
    output logic        data_done,
    output logic [15:0] data_rdata
);

    logic        instr_access;
    mem_req_t    instr_req;
    logic        instr_ack;
    logic        data_access;
    mem_req_t    data_req;
    logic        data_ack;
    logic [15:0] rdata;         // shared by both masters.
    logic        q_access;
    mem_req_t    q_req;
    logic        q_ack;
    logic [15:0] q_rdata;

    prefetch_queue prefetch_i (
        .clk         (clk),
        .reset       (reset),
        .fetch_start (fetch_start),
        .fetch_addr  (fetch_addr),
        .instr_pop   (instr_pop),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .bus_access  (instr_access),
        .bus_req     (instr_req),
        .bus_ack     (instr_ack),
        .bus_rdata   (rdata)
    );

    data_port data_i (
        .clk        (clk),
        .reset      (reset),
        .data_start (data_start),
        .data_addr  (data_addr),
        .data_word  (data_word),
        .data_wr    (data_wr),
        .data_wdata (data_wdata),
        .data_busy  (data_busy),
        .data_done  (data_done),
        .data_rdata (data_rdata),
        .bus_access (data_access),
        .bus_req    (data_req),
        .bus_ack    (data_ack),
        .bus_rdata  (rdata)
    );

    mem_arbiter arbiter_i (
        .clk          (clk),
        .reset        (reset),
        .instr_access (instr_access),
        .instr_req    (instr_req),
        .instr_ack    (instr_ack),
        .data_access  (data_access),
        .data_req     (data_req),
        .data_ack     (data_ack),
        .bus_rdata_in (q_rdata),
        .rdata        (rdata),
        .q_access     (q_access),
        .q_req        (q_req),
        .q_ack        (q_ack)
    );

    sram_ctrl sram_i (
        .clk    (clk),
        .reset  (reset),
        .access (q_access),
        .req    (q_req),
        .ack    (q_ack),
        .rdata  (q_rdata)
    );

endmodule

/* tests/mem_subsystem_tb.sv */
`timescale 1ns/100ps

module mem_subsystem_tb
    import mem_bus_pkg::*;
;

    localparam int max_cycles = 6000;       // about 200 ops at 12 cycles, with margin.

    logic        clk;
    logic        reset;
    logic        fetch_start;
    word_addr_t  fetch_addr;
    logic        instr_pop;
    logic        instr_valid;
    logic [15:0] instr_word;
    logic        data_start;
    logic [19:0] data_addr;
    logic        data_word;
    logic        data_wr;
    logic [15:0] data_wdata;
    logic        data_busy;
    logic        data_done;
    logic [15:0] data_rdata;

    logic [7:0]  ref_mem [int];             // byte-addressed reference memory.
    logic [31:0] lcg_state;
    int          cycles;
    logic        quiet;                     // window right after reset.
    logic        read_pending;
    logic [15:0] exp_rdata;
    logic [15:0] exp_instr;
    word_addr_t  exp_addr;                  // word address of the next pop.

    mem_subsystem_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .fetch_start (fetch_start),
        .fetch_addr  (fetch_addr),
        .instr_pop   (instr_pop),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .data_start  (data_start),
        .data_addr   (data_addr),
        .data_word   (data_word),
        .data_wr     (data_wr),
        .data_wdata  (data_wdata),
        .data_busy   (data_busy),
        .data_done   (data_done),
        .data_rdata  (data_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'({16'd0, lcg_state[31:16]});
    endfunction

    function automatic logic [7:0] stored_byte(input logic [19:0] addr);
        return ref_mem[int'(addr)];
    endfunction

    function automatic logic [15:0] word_at(input word_addr_t addr);
        return {stored_byte({addr, 1'b1}), stored_byte({addr, 1'b0})};
    endfunction

    // little endian, byte reads come back zero-extended.
    function automatic logic [15:0] expected_read(input logic [19:0] addr, input logic word);
        if (word)
            return {stored_byte(addr + 20'd1), stored_byte(addr)};
        return {8'h00, stored_byte(addr)};
    endfunction

    function automatic void apply_write(input logic [19:0] addr, input logic word,
                                        input logic [15:0] wdata);
        ref_mem[int'(addr)] = wdata[7:0];
        if (word)
            ref_mem[int'(addr + 20'd1)] = wdata[15:8];
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] got);
        $display("** Error: %s expected 0x%h, got 0x%h", name, exp, got);
        $display("TEST FAILED");
        $fatal(1, "%s mismatch", name);
    endtask

    task automatic data_access(input logic [19:0] addr, input logic word, input logic wr,
                               input logic [15:0] wdata);
        @(negedge clk);
        read_pending = ~wr;
        if (wr)
            apply_write(addr, word, wdata);
        else
            exp_rdata = expected_read(addr, word);
        data_start = 1'b1;
        data_addr = addr;
        data_word = word;
        data_wr = wr;
        data_wdata = wdata;
        @(negedge clk);
        data_start = 1'b0;
        while (!data_done)
            @(negedge clk);
    endtask

    task automatic restart_fetch(input word_addr_t addr);
        @(negedge clk);
        instr_pop = 1'b0;
        fetch_start = 1'b1;
        fetch_addr = addr;
        exp_addr = addr;
        @(negedge clk);
        fetch_start = 1'b0;
    endtask

    // stall_pct is the chance in percent of holding instr_pop low in a cycle.
    task automatic pop_words(input int count, input int stall_pct);
        int popped;
        popped = 0;
        instr_pop = 1'b0;
        while (popped < count) begin
            @(negedge clk);
            if (instr_pop) begin
                exp_addr = exp_addr + 19'd1;
                popped++;
            end
            instr_pop = 1'b0;
            if (popped < count && instr_valid && (next_rand() % 100) >= stall_pct) begin
                exp_instr = word_at(exp_addr);
                instr_pop = 1'b1;
            end
        end
    endtask

    task automatic random_data_ops(input int count);
        logic [19:0] addr;
        logic        word;
        logic        wr;
        for (int i = 0; i < count; i++) begin
            addr = 20'(next_rand() % 64);
            word = (next_rand() % 2) == 1;
            wr = (next_rand() % 2) == 1;
            if (word && addr == 20'd63)
                addr = 20'd62;      // stay inside the filled region.
            data_access(addr, word, wr, 16'(next_rand()));
        end
    endtask

    rdata_check_a: assert property (@(posedge clk) disable iff (reset)
        data_done && read_pending |-> data_rdata == exp_rdata)
        else report_mismatch("data_rdata", $sampled(exp_rdata), $sampled(data_rdata));

    instr_check_a: assert property (@(posedge clk) disable iff (reset)
        instr_pop && instr_valid |-> instr_word == exp_instr)
        else report_mismatch("instr_word", $sampled(exp_instr), $sampled(instr_word));

    idle_after_reset_a: assert property (@(posedge clk) disable iff (reset)
        quiet |-> !instr_valid && !data_busy && !data_done)
        else begin
            $display("** Error: after reset instr_valid 0x%h data_busy 0x%h data_done 0x%h",
                     $sampled(instr_valid), $sampled(data_busy), $sampled(data_done));
            $display("TEST FAILED");
            $fatal(1, "outputs not idle after reset");
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $fatal(1, "run timed out");
        end
    end

    initial begin
        lcg_state = 32'd40248;
        cycles = 0;
        quiet = 1'b1;
        read_pending = 1'b0;
        exp_rdata = '0;
        exp_instr = '0;
        exp_addr = '0;
        reset = 1'b1;
        fetch_start = 1'b0;
        fetch_addr = '0;
        instr_pop = 1'b0;
        data_start = 1'b0;
        data_addr = '0;
        data_word = 1'b0;
        data_wr = 1'b0;
        data_wdata = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        repeat (3) @(negedge clk);
        quiet = 1'b0;

        // data region at bytes 0x000 to 0x03f, code region at words 0x100 to 0x11f.
        for (int i = 0; i < 32; i++)
            data_access(20'(2 * i), 1'b1, 1'b1, 16'(next_rand()));
        for (int i = 0; i < 32; i++)
            data_access(20'(20'h200 + 2 * i), 1'b1, 1'b1, 16'(next_rand()));

        data_access(20'h010, 1'b1, 1'b1, 16'(next_rand()));
        data_access(20'h010, 1'b1, 1'b0, 16'h0000);

        data_access(20'h020, 1'b0, 1'b1, 16'(next_rand()));
        data_access(20'h021, 1'b0, 1'b1, 16'(next_rand()));
        data_access(20'h020, 1'b1, 1'b0, 16'h0000);
        data_access(20'h020, 1'b0, 1'b0, 16'h0000);
        data_access(20'h021, 1'b0, 1'b0, 16'h0000);

        data_access(20'h031, 1'b1, 1'b1, 16'(next_rand()));
        data_access(20'h031, 1'b1, 1'b0, 16'h0000);
        for (int i = 0; i < 4; i++)
            data_access(20'(20'h030 + i), 1'b0, 1'b0, 16'h0000);
        data_access(20'h030, 1'b1, 1'b0, 16'h0000);
        data_access(20'h032, 1'b1, 1'b0, 16'h0000);

        // sequential fetch with a long stall so the queue fills up.
        restart_fetch(19'h104);
        pop_words(6, 0);
        instr_pop = 1'b0;
        repeat (40) @(negedge clk);
        pop_words(10, 50);
        instr_pop = 1'b0;

        // second flush while the first fetch is still on the bus.
        @(negedge clk);
        fetch_start = 1'b1;
        fetch_addr = 19'h108;
        @(negedge clk);
        fetch_addr = 19'h110;
        exp_addr = 19'h110;
        @(negedge clk);
        fetch_start = 1'b0;
        pop_words(6, 0);
        instr_pop = 1'b0;

        fork
            begin
                restart_fetch(19'h100);
                pop_words(28, 30);
                instr_pop = 1'b0;
            end
            random_data_ops(60);
        join

        repeat (4) @(negedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* compile.f */
design/cpu_cfg_pkg.sv
design/mem_bus_pkg.sv
design/prefetch_queue.sv
design/data_port.sv
design/mem_arbiter.sv
design/sram_ctrl.sv
design/mem_subsystem_top.sv
tests/mem_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module mem_subsystem_tb \
    -o mem_subsystem_sim

./obj_dir/mem_subsystem_sim
